// File: hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int WORD_W = 32;
  localparam int LINE_W = 128;
  localparam int ADDR_W = 32;
  localparam int LANES  = LINE_W / WORD_W;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  typedef struct packed {
    logic              valid;
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] data;
  } rt_req_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } mc_req_t;

  typedef struct packed {
    logic              en;
    logic              we;
    logic [15:0]       row;   // Only the low ROW_W bits reach the ram
    logic [WORD_W-1:0] data;
  } bank_req_t;

  // Banks below the lane offset hold the wrapped tail of the line one row up
  function automatic logic [15:0] bank_row(input logic [ADDR_W-1:0] addr,
                                           input int unsigned lane,
                                           input int unsigned row_w);
    logic [31:0] row;
    row = 32'(addr >> 4) + ((lane < 32'(addr[3:2])) ? 32'd1 : 32'd0);
    return 16'(row & ((32'd1 << row_w) - 32'd1));
  endfunction

  function automatic logic [WORD_W-1:0] lane_word(input logic [LINE_W-1:0] line,
                                                  input logic [ADDR_W-1:0] addr,
                                                  input int unsigned lane);
    logic [1:0] k;
    k = 2'(lane) - addr[3:2];  // Line word that lands on this bank
    return line[k*WORD_W +: WORD_W];
  endfunction

endpackage

`default_nettype wire

// File: hdl/ram.sv
`default_nettype none

module ram #(
  parameter int ADDR_WIDTH = 6,
  parameter int DATA_WIDTH = 32
) (
  input  wire logic                  clk,
  input  wire logic                  we,
  input  wire logic [ADDR_WIDTH-1:0] addr,
  input  wire logic [DATA_WIDTH-1:0] din,
  output logic      [DATA_WIDTH-1:0] dout
);

  logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= din;
    end
    dout <= mem[addr];  // Old contents come out on a write
  end

endmodule

`default_nettype wire

// File: hdl/rt_request_router.sv
`default_nettype none

module rt_request_router
  import mem_pkg::*;
#(
  parameter int NUM_RT    = 4,
  parameter int NUM_GROUP = 4,
  parameter int ROW_W     = 6,
  localparam int GRP_W    = (NUM_GROUP > 1) ? $clog2(NUM_GROUP) : 1,
  localparam int OWN_W    = (NUM_RT > 1) ? $clog2(NUM_RT) : 1
) (
  input  rt_req_t              rt_req   [NUM_RT],
  output bank_req_t            rt_bank  [NUM_GROUP][LANES],
  output logic     [OWN_W-1:0] rt_owner [NUM_GROUP],
  output logic [NUM_GROUP-1:0] rt_hit
);

  logic [GRP_W-1:0] port_grp [NUM_RT];
  rt_req_t          win      [NUM_GROUP];

  // ##########################################################
  // Group decode and fixed-priority pick

  always_comb begin
    for (int p = 0; p < NUM_RT; p++) begin
      port_grp[p] = rt_req[p].addr[ROW_W+4 +: GRP_W];  // Bits just above the word index
    end

    for (int g = 0; g < NUM_GROUP; g++) begin
      rt_hit[g]   = 1'b0;
      rt_owner[g] = '0;
      for (int p = NUM_RT - 1; p >= 0; p--) begin  // Walk down so the lowest index wins
        if (rt_req[p].valid && port_grp[p] == GRP_W'(g)) begin
          rt_hit[g]   = 1'b1;
          rt_owner[g] = OWN_W'(p);
        end
      end

      win[g] = rt_req[rt_owner[g]];

      // ######################################################
      // Rotate the winning line onto the four banks

      for (int b = 0; b < LANES; b++) begin
        rt_bank[g][b].en   = rt_hit[g];
        rt_bank[g][b].we   = rt_hit[g] && (win[g].op == OP_WRITE);
        rt_bank[g][b].row  = bank_row(win[g].addr, b, ROW_W);
        rt_bank[g][b].data = lane_word(win[g].data, win[g].addr, b);
      end
    end
  end

  always_comb begin
    for (int g = 0; g < NUM_GROUP; g++) begin
      if (rt_hit[g]) begin
        a_hit_owner: assert final (rt_req[rt_owner[g]].valid &&
                                   port_grp[rt_owner[g]] == GRP_W'(g));
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/mc_request_decoder.sv
`default_nettype none

module mc_request_decoder
  import mem_pkg::*;
#(
  parameter int NUM_GROUP = 4,
  parameter int ROW_W     = 6,
  localparam int GRP_W    = (NUM_GROUP > 1) ? $clog2(NUM_GROUP) : 1
) (
  input  mc_req_t          mc_req,
  output bank_req_t        mc_bank [LANES],
  output logic [GRP_W-1:0] mc_group
);

  assign mc_group = mc_req.addr[ROW_W+4 +: GRP_W];

  always_comb begin
    for (int b = 0; b < LANES; b++) begin
      mc_bank[b].en   = mc_req.valid;
      mc_bank[b].we   = 1'b0;                    // The MC port only reads
      mc_bank[b].row  = bank_row(mc_req.addr, b, ROW_W);
      mc_bank[b].data = '0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/bank_array.sv
`default_nettype none

module bank_array
  import mem_pkg::*;
#(
  parameter int NUM_RT    = 4,
  parameter int NUM_GROUP = 4,
  parameter int ROW_W     = 6,
  localparam int GRP_W    = (NUM_GROUP > 1) ? $clog2(NUM_GROUP) : 1,
  localparam int OWN_W    = (NUM_RT > 1) ? $clog2(NUM_RT) : 1
) (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  bank_req_t                  rt_bank  [NUM_GROUP][LANES],
  input  wire logic      [OWN_W-1:0] rt_owner [NUM_GROUP],
  input  wire logic  [NUM_GROUP-1:0] rt_hit,
  input  mc_req_t                    mc_req,
  input  bank_req_t                  mc_bank  [LANES],
  input  wire logic      [GRP_W-1:0] mc_group,
  output logic          [NUM_RT-1:0] rt_rdy,
  output logic          [LINE_W-1:0] rt_rdata [NUM_RT],
  output logic                       mc_rdy,
  output logic          [LINE_W-1:0] mc_rdata
);

  logic [NUM_GROUP-1:0] mc_sel;
  logic [NUM_GROUP-1:0] rt_sel;
  bank_req_t            bank_sel [NUM_GROUP][LANES];
  logic           [1:0] rot      [NUM_GROUP];
  logic    [WORD_W-1:0] dout     [NUM_GROUP][LANES];
  logic [NUM_GROUP-1:0] port_gnt [NUM_RT];

  logic [NUM_GROUP-1:0] mc_srv_q;
  logic [NUM_GROUP-1:0] rt_srv_q;
  logic     [OWN_W-1:0] own_q    [NUM_GROUP];
  logic           [1:0] rot_q    [NUM_GROUP];
  logic    [LINE_W-1:0] grp_line [NUM_GROUP];

  // Lanes below the offset sit one row above the last bank, so counting them gives the offset
  function automatic logic [1:0] rot_of(input bank_req_t req [LANES]);
    logic [1:0] cnt;
    cnt = '0;
    for (int b = 0; b < LANES - 1; b++) begin
      if (req[b].row[ROW_W-1:0] != req[LANES-1].row[ROW_W-1:0]) begin
        cnt = cnt + 2'd1;
      end
    end
    return cnt;
  endfunction

  // ##########################################################
  // Grant per group, MC first

  always_comb begin
    for (int p = 0; p < NUM_RT; p++) begin
      port_gnt[p] = '0;
    end
    for (int g = 0; g < NUM_GROUP; g++) begin
      mc_sel[g] = mc_req.valid && (mc_group == GRP_W'(g));
      rt_sel[g] = rt_hit[g] && !mc_sel[g];
      for (int b = 0; b < LANES; b++) begin
        bank_sel[g][b] = mc_sel[g] ? mc_bank[b] : rt_bank[g][b];
      end
      rot[g] = rot_of(bank_sel[g]);
      if (rt_sel[g]) begin
        port_gnt[rt_owner[g]][g] = 1'b1;
      end
    end
  end

  for (genvar g = 0; g < NUM_GROUP; g++) begin : g_grp
    for (genvar b = 0; b < LANES; b++) begin : g_bank
      ram #(
        .ADDR_WIDTH (ROW_W),
        .DATA_WIDTH (WORD_W)
      ) bank_inst (
        .clk  (clk),
        .we   (bank_sel[g][b].en & bank_sel[g][b].we),
        .addr (bank_sel[g][b].row[ROW_W-1:0]),
        .din  (bank_sel[g][b].data),
        .dout (dout[g][b])
      );

      // A write leaking onto an MC lane would corrupt RT data in this group
      a_mc_no_write: assert property (@(posedge clk) disable iff (!arst_n)
        mc_sel[g] |-> !bank_sel[g][b].we);
    end
  end

  // ##########################################################
  // Served requester, one cycle behind the rams

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mc_srv_q <= '0;
      rt_srv_q <= '0;
    end else begin
      mc_srv_q <= mc_sel;
      rt_srv_q <= rt_sel;
    end
  end

  always_ff @(posedge clk) begin
    for (int g = 0; g < NUM_GROUP; g++) begin
      own_q[g] <= rt_owner[g];
      rot_q[g] <= rot[g];
    end
  end

  always_comb begin
    logic [1:0] idx;
    mc_rdy   = |mc_srv_q;
    mc_rdata = '0;
    rt_rdy   = '0;
    for (int p = 0; p < NUM_RT; p++) begin
      rt_rdata[p] = '0;
    end
    for (int g = 0; g < NUM_GROUP; g++) begin
      for (int k = 0; k < LANES; k++) begin
        idx = 2'(k) + rot_q[g];  // Undo the lane rotation
        grp_line[g][k*WORD_W +: WORD_W] = dout[g][idx];
      end
      if (mc_srv_q[g]) begin
        mc_rdata = grp_line[g];
      end
      if (rt_srv_q[g]) begin
        rt_rdy[own_q[g]]   = 1'b1;
        rt_rdata[own_q[g]] = grp_line[g];
      end
    end
  end

  for (genvar p = 0; p < NUM_RT; p++) begin : g_chk
    a_one_group: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(port_gnt[p]));
  end

  a_mc_rdy_hold: assert property (@(posedge clk) disable iff (!arst_n)
    mc_rdy && !mc_req.valid |=> !mc_rdy);

endmodule

`default_nettype wire

// File: hdl/mem_main.sv
`default_nettype none

module mem_main
  import mem_pkg::*;
#(
  parameter int NUM_RT    = 4,
  parameter int NUM_GROUP = 4,
  parameter int ROW_W     = 6
) (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  rt_req_t                rt_req   [NUM_RT],
  input  mc_req_t                mc_req,
  output logic      [NUM_RT-1:0] rt_rdy,
  output logic      [LINE_W-1:0] rt_rdata [NUM_RT],
  output logic                   mc_rdy,
  output logic      [LINE_W-1:0] mc_rdata
);

  localparam int GRP_W = (NUM_GROUP > 1) ? $clog2(NUM_GROUP) : 1;
  localparam int OWN_W = (NUM_RT > 1) ? $clog2(NUM_RT) : 1;

  bank_req_t            rt_bank  [NUM_GROUP][LANES];
  logic     [OWN_W-1:0] rt_owner [NUM_GROUP];
  logic [NUM_GROUP-1:0] rt_hit;
  bank_req_t            mc_bank  [LANES];
  logic     [GRP_W-1:0] mc_group;

  rt_request_router #(
    .NUM_RT    (NUM_RT),
    .NUM_GROUP (NUM_GROUP),
    .ROW_W     (ROW_W)
  ) rt_request_router_inst (
    .rt_req   (rt_req),
    .rt_bank  (rt_bank),
    .rt_owner (rt_owner),
    .rt_hit   (rt_hit)
  );

  mc_request_decoder #(
    .NUM_GROUP (NUM_GROUP),
    .ROW_W     (ROW_W)
  ) mc_request_decoder_inst (
    .mc_req   (mc_req),
    .mc_bank  (mc_bank),
    .mc_group (mc_group)
  );

  bank_array #(
    .NUM_RT    (NUM_RT),
    .NUM_GROUP (NUM_GROUP),
    .ROW_W     (ROW_W)
  ) bank_array_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .rt_bank  (rt_bank),
    .rt_owner (rt_owner),
    .rt_hit   (rt_hit),
    .mc_req   (mc_req),
    .mc_bank  (mc_bank),
    .mc_group (mc_group),
    .rt_rdy   (rt_rdy),
    .rt_rdata (rt_rdata),
    .mc_rdy   (mc_rdy),
    .mc_rdata (mc_rdata)
  );

endmodule

`default_nettype wire

// File: sim/tb_mem_main.sv
`default_nettype none

module tb_mem_main
  import mem_pkg::*;
();

  localparam int NUM_RT      = 4;
  localparam int NUM_GROUP   = 4;
  localparam int ROW_W       = 6;
  localparam int GRP_W       = $clog2(NUM_GROUP);
  localparam int WPG         = 1 << (ROW_W + 2);  // Words per group
  localparam int TEST_CYCLES = 520;

  logic                clk;
  logic                arst_n;
  rt_req_t             rt_req   [NUM_RT];
  mc_req_t             mc_req;
  logic   [NUM_RT-1:0] rt_rdy;
  logic   [LINE_W-1:0] rt_rdata [NUM_RT];
  logic                mc_rdy;
  logic   [LINE_W-1:0] mc_rdata;

  logic [WORD_W-1:0] model    [NUM_GROUP][WPG];
  logic   [NUM_RT:0] exp_rdy;              // MC sits in the top bit
  logic   [NUM_RT:0] exp_rd;
  logic [LINE_W-1:0] exp_line [NUM_RT+1];
  logic       [31:0] rng;
  int                errors;
  int                checks;
  int                test_err;
  int                tests;

  mem_main mem_main_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .rt_req   (rt_req),
    .mc_req   (mc_req),
    .rt_rdy   (rt_rdy),
    .rt_rdata (rt_rdata),
    .mc_rdy   (mc_rdy),
    .mc_rdata (mc_rdata)
  );

  always #4 clk = ~clk;

  initial begin
    repeat (TEST_CYCLES * 4 + 200) @(posedge clk);
    $display("Timeout: requests were still waiting for a ready pulse when time ran out");
    $display(">>> FAIL");
    $finish;
  end

  // ##########################################################
  // Random numbers, addresses and the flat memory model

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [ADDR_W-1:0] make_addr(input int g, input int w);
    return (ADDR_W'(g) << (ROW_W + 4)) | (ADDR_W'(w % WPG) << 2);
  endfunction

  function automatic int grp_of(input logic [ADDR_W-1:0] addr);
    return int'(addr[ROW_W+4 +: GRP_W]);
  endfunction

  function automatic int word_of(input logic [ADDR_W-1:0] addr);
    return int'(addr[2 +: ROW_W+2]);
  endfunction

  function automatic logic [WORD_W-1:0] fill_word(input int g, input int w);
    return (32'(g * WPG + w) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
  endfunction

  function automatic logic [LINE_W-1:0] rand_line();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  function automatic logic [LINE_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
    logic [LINE_W-1:0] line;
    for (int k = 0; k < LANES; k++) begin
      line[k*WORD_W +: WORD_W] = model[grp_of(addr)][(word_of(addr) + k) % WPG];  // Wraps in group
    end
    return line;
  endfunction

  task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] line);
    for (int k = 0; k < LANES; k++) begin
      model[grp_of(addr)][(word_of(addr) + k) % WPG] = line[k*WORD_W +: WORD_W];
    end
  endtask

  // ##########################################################
  // Checks and the per-cycle engine

  task automatic check_rdy(input logic [NUM_RT:0] got, input logic [NUM_RT:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: ready bits {mc, rt} are %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_line(input logic [LINE_W-1:0] got, input logic [LINE_W-1:0] exp,
                            input string who);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, who, got, exp);
    end
  endtask

  // Applies the grant rule to what is driven now, for the coming rising edge
  task automatic predict();
    logic found;
    exp_rdy = '0;
    exp_rd  = '0;
    for (int g = 0; g < NUM_GROUP; g++) begin
      found = mc_req.valid && grp_of(mc_req.addr) == g;
      if (found) begin
        exp_rdy[NUM_RT]  = 1'b1;
        exp_rd[NUM_RT]   = 1'b1;
        exp_line[NUM_RT] = model_read(mc_req.addr);
      end
      for (int q = 0; q < NUM_RT; q++) begin
        if (!found && rt_req[q].valid && grp_of(rt_req[q].addr) == g) begin
          found      = 1'b1;
          exp_rdy[q] = 1'b1;
          if (rt_req[q].op == OP_WRITE) begin
            model_write(rt_req[q].addr, rt_req[q].data);
          end else begin
            exp_rd[q]   = 1'b1;
            exp_line[q] = model_read(rt_req[q].addr);
          end
        end
      end
    end
  endtask

  task automatic step();
    predict();
    @(negedge clk);
    check_rdy({mc_rdy, rt_rdy}, exp_rdy);
    for (int p = 0; p < NUM_RT; p++) begin
      if (exp_rd[p]) begin
        check_line(rt_rdata[p], exp_line[p], $sformatf("rt_rdata[%0d]", p));
      end
      if (rt_rdy[p]) begin
        rt_req[p].valid = 1'b0;  // Served, so the port is free next cycle
      end
    end
    if (exp_rd[NUM_RT]) begin
      check_line(mc_rdata, exp_line[NUM_RT], "mc_rdata");
    end
    if (mc_rdy) begin
      mc_req.valid = 1'b0;
    end
  endtask

  function automatic logic busy();
    logic any;
    any = mc_req.valid;
    for (int p = 0; p < NUM_RT; p++) begin
      any = any | rt_req[p].valid;
    end
    return any;
  endfunction

  task automatic drain();
    while (busy()) begin
      step();
    end
  endtask

  task automatic issue_rt(input int p, input mem_op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [LINE_W-1:0] data);
    rt_req[p].valid = 1'b1;
    rt_req[p].op    = op;
    rt_req[p].addr  = addr;
    rt_req[p].data  = data;
  endtask

  task automatic issue_mc(input logic [ADDR_W-1:0] addr);
    mc_req.valid = 1'b1;
    mc_req.addr  = addr;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %-10s %s, %0d errors", name, (errors == test_err) ? "ok" : "failed",
             errors - test_err);
    test_err = errors;
  endtask

  // ##########################################################
  // Test sequence

  initial begin
    logic [LINE_W-1:0] line;
    logic [ADDR_W-1:0] a;
    logic [ADDR_W-1:0] rd_q [$];
    logic       [31:0] r;
    int                w;
    clk      = 1'b0;
    arst_n   = 1'b0;
    rng      = 32'd8;
    errors   = 0;
    checks   = 0;
    test_err = 0;
    tests    = 0;
    mc_req   = '0;
    exp_rdy  = '0;
    exp_rd   = '0;
    for (int p = 0; p < NUM_RT; p++) begin
      rt_req[p] = '0;
    end

    // Requests held through reset must not be served
    for (int p = 0; p < NUM_RT; p++) begin
      issue_rt(p, OP_READ, make_addr(p, 0), '0);
    end
    issue_mc(make_addr(0, 4));
    repeat (5) begin
      @(negedge clk);
      check_rdy({mc_rdy, rt_rdy}, '0);
    end
    mc_req.valid = 1'b0;
    for (int p = 0; p < NUM_RT; p++) begin
      rt_req[p].valid = 1'b0;
    end
    arst_n = 1'b1;
    repeat (2) step();
    end_test("reset");

    // Every port fills its own group so the whole memory holds known data
    for (int row = 0; row < WPG / LANES; row++) begin
      for (int g = 0; g < NUM_GROUP; g++) begin
        for (int k = 0; k < LANES; k++) begin
          line[k*WORD_W +: WORD_W] = fill_word(g, row * LANES + k);
        end
        issue_rt(g, OP_WRITE, make_addr(g, row * LANES), line);
      end
      drain();
    end
    issue_rt(1, OP_WRITE, make_addr(2, 40), rand_line());
    drain();
    issue_rt(1, OP_READ, make_addr(2, 40), '0);
    drain();
    issue_rt(0, OP_READ, make_addr(3, 100), '0);
    drain();
    end_test("aligned");

    for (int k = 0; k < LANES; k++) begin
      w = (k < 3) ? 16 * k + 4 + k + 1 : WPG - 1;  // Offsets 1, 2, 3, then the last word
      a = make_addr(k, w);
      issue_rt(1, OP_WRITE, a, rand_line());
      drain();
      rd_q.push_back(a);
      rd_q.push_back(make_addr(k, w & ~3));
      rd_q.push_back(make_addr(k, (w & ~3) + 4));
    end
    foreach (rd_q[i]) begin
      issue_mc(rd_q[i]);
      drain();
    end
    end_test("unaligned");

    a = make_addr(3, 60);
    issue_rt(1, OP_WRITE, a, rand_line());
    issue_rt(3, OP_READ, a, '0);
    drain();
    issue_rt(2, OP_WRITE, make_addr(0, 12), rand_line());
    issue_rt(0, OP_READ, make_addr(0, 13), '0);
    drain();
    end_test("conflict");

    a = make_addr(1, 77);
    issue_mc(a);
    issue_rt(0, OP_WRITE, a, rand_line());
    drain();
    issue_mc(make_addr(2, 9));
    issue_rt(2, OP_READ, make_addr(0, 30), '0);
    drain();
    end_test("mc_prio");

    for (int c = 0; c < 400; c++) begin
      for (int p = 0; p < NUM_RT; p++) begin
        if (!rt_req[p].valid && next_rand() % 3 != 0) begin
          r = next_rand();
          a = next_rand() & ~(ADDR_W'(WPG - 16) << 2);  // Small word window, random upper bits
          issue_rt(p, r[0] ? OP_WRITE : OP_READ, a, rand_line());
        end
      end
      if (!mc_req.valid && next_rand() % 3 == 0) begin
        issue_mc(next_rand() & ~(ADDR_W'(WPG - 16) << 2));
      end
      step();
    end
    drain();
    end_test("random");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mem_main.f
hdl/mem_pkg.sv
hdl/ram.sv
hdl/rt_request_router.sv
hdl/mc_request_decoder.sv
hdl/bank_array.sv
hdl/mem_main.sv
sim/tb_mem_main.sv

// File: Bender.yml
package:
  name: mem_main

sources:
  - hdl/mem_pkg.sv
  - hdl/ram.sv
  - hdl/rt_request_router.sv
  - hdl/mc_request_decoder.sv
  - hdl/bank_array.sv
  - hdl/mem_main.sv
  - target: test
    files:
      - sim/tb_mem_main.sv
